// ==== bench/stepper_tb.sv ====
module stepper_tb;

	import stepper_pkg::*;

	localparam int QUEUE_DEPTH = 4;
	localparam int TICK_DIV = 4;
	localparam int CLK_PERIOD = 20;
	localparam int N_CMDS = 10;

	logic clk;
	logic reset;
	logic cmd_valid;
	logic [PULSE_NUM_W-1:0] cmd_pulse_num;
	logic [PULSE_WIDTH_W-1:0] cmd_pulse_width;
	logic cmd_dir;
	logic cmd_credit;
	logic step;
	logic dir;
	logic busy;
	logic move_done;

	// command table with the expected pulse count per entry
	int tab_num [N_CMDS];
	int tab_width [N_CMDS];
	logic tab_dir [N_CMDS];
	int tab_exp [N_CMDS];
	bit table_ready = 1'b0;

	integer seed = 52393;
	longint wd_limit;
	int pushes = 0;
	int credits_returned = 0;
	int done_idx = 0;
	int pulse_count = 0;
	int high_clocks = 0;
	logic prev_step = 1'b0;
	bit in_move = 1'b0;
	stepper_state_e dbg_state;

	stepper_top #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.TICK_DIV(TICK_DIV)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_pulse_num(cmd_pulse_num),
		.cmd_pulse_width(cmd_pulse_width),
		.cmd_dir(cmd_dir),
		.cmd_credit(cmd_credit),
		.step(step),
		.dir(dir),
		.busy(busy),
		.move_done(move_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check(input string name, input longint expected, input longint actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %0d actual %0d", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	// fills one table row and applies the zero-length rule to the expected count
	task automatic set_entry(input int i, input int num, input int width, input logic d);
		tab_num[i] = num;
		tab_width[i] = width;
		tab_dir[i] = d;
		tab_exp[i] = (num == 0 || width == 0) ? 0 : num;
	endtask

	// pulse monitor sampled mid-cycle
	always @(negedge clk) begin
		if (!reset) begin
			if (step) begin
				high_clocks++;
			end
			// rising edge of step
			if (step && !prev_step) begin
				pulse_count++;
				in_move = 1'b1;
				check($sformatf("cmd %0d dir", done_idx), tab_dir[done_idx], dir);
			end
			// busy holds from the first step rise through move_done
			if (in_move) begin
				check("busy during move", 1, busy);
			end
			// on the falling edge the high time must be width ticks
			if (!step && prev_step) begin
				check($sformatf("cmd %0d pulse high clocks", done_idx),
					tab_width[done_idx] * TICK_DIV, high_clocks);
				high_clocks = 0;
			end
			if (move_done) begin
				if (done_idx >= N_CMDS) begin
					$display("move_done seen after all commands had already finished");
					$display("STATUS: FAIL");
					$fatal(1, "extra move_done");
				end
				check($sformatf("cmd %0d pulse count", done_idx), tab_exp[done_idx], pulse_count);
				check("busy at move_done", 1, busy);
				done_idx++;
				pulse_count = 0;
				in_move = 1'b0;
			end
			if (cmd_credit) begin
				credits_returned++;
			end
			prev_step = step;
		end
	end

	// watchdog with a budget from the command table
	initial begin
		wait (table_ready);
		#(wd_limit);
		dbg_state = dut_i.ctrl_i.cur_state;
		$display("run timed out waiting for move_done, %0d of %0d done, controller in %s",
			done_idx, N_CMDS, dbg_state.name());
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		cmd_valid = 1'b0;
		cmd_pulse_num = '0;
		cmd_pulse_width = '0;
		cmd_dir = 1'b0;
		reset = 1'b1;

		// first four go back to back and fill the queue
		set_entry(0, 3, 2, 1'b1);
		set_entry(1, 1, 1, 1'b0);
		set_entry(2, 0, 3, 1'b1);
		set_entry(3, 2, 0, 1'b0);
		set_entry(4, 4, 1, 1'b1);
		set_entry(5, 2, {$random(seed)} % 6, 1'b0);
		set_entry(6, 5, 3, 1'b0);
		set_entry(7, 3, {$random(seed)} % 6, 1'b1);
		set_entry(8, 1, {$random(seed)} % 6, 1'b0);
		set_entry(9, 2, 4, 1'b1);
		// reset, idle check and drain on top of the per-command budget
		wd_limit = (16 + 64) * CLK_PERIOD;
		for (int i = 0; i < N_CMDS; i++) begin
			wd_limit += (tab_num[i] * (tab_width[i] + 1) + 4) * TICK_DIV * CLK_PERIOD * 2;
		end
		table_ready = 1'b1;

		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;

		// nothing moves before the first push
		repeat (12) begin
			@(negedge clk);
			check("idle step", 0, step);
			check("idle busy", 0, busy);
			check("idle move_done", 0, move_done);
			check("idle cmd_credit", 0, cmd_credit);
		end

		@(posedge clk);
		#2;
		for (int i = 0; i < N_CMDS; i++) begin
			// hold off while the host has no credit
			while (pushes - credits_returned >= QUEUE_DEPTH) begin
				@(posedge clk);
				#2;
			end
			cmd_valid = 1'b1;
			cmd_pulse_num = PULSE_NUM_W'(tab_num[i]);
			cmd_pulse_width = PULSE_WIDTH_W'(tab_width[i]);
			cmd_dir = tab_dir[i];
			pushes++;
			@(posedge clk);
			#2;
			cmd_valid = 1'b0;
		end

		while (done_idx < N_CMDS) begin
			@(posedge clk);
		end
		repeat (4 * TICK_DIV) @(negedge clk);

		// queue drained and every credit back with the host
		check("busy after drain", 0, busy);
		check("step after drain", 0, step);
		check("credits returned", N_CMDS, credits_returned);
		check("host credit", QUEUE_DEPTH, QUEUE_DEPTH - pushes + credits_returned);
		$display("STATUS: PASS");
		$finish;
	end

endmodule : stepper_tb

// ==== hw/move_cmd_queue.sv ====
module move_cmd_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic [stepper_pkg::PULSE_NUM_W-1:0] push_pulse_num,
	input logic [stepper_pkg::PULSE_WIDTH_W-1:0] push_pulse_width,
	input logic push_dir,
	input logic pop,
	output logic empty,
	output logic [stepper_pkg::PULSE_NUM_W-1:0] head_pulse_num,
	output logic [stepper_pkg::PULSE_WIDTH_W-1:0] head_pulse_width,
	output logic head_dir,
	output logic credit
);

	import stepper_pkg::*;

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	// one array per command field
	logic [PULSE_NUM_W-1:0] num_mem [QUEUE_DEPTH];
	logic [PULSE_WIDTH_W-1:0] width_mem [QUEUE_DEPTH];
	logic [QUEUE_DEPTH-1:0] dir_mem;

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic full;
	logic do_push;
	logic do_pop;

	// circular increment, wraps at the last entry
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign empty = (fill == '0);
	assign full = (fill == CNT_W'(QUEUE_DEPTH));
	// push into a full queue is dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// head fields straight off the read pointer
	assign head_pulse_num = num_mem[rd_ptr];
	assign head_pulse_width = width_mem[rd_ptr];
	assign head_dir = dir_mem[rd_ptr];

	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			num_mem[wr_ptr] <= push_pulse_num;
			width_mem[wr_ptr] <= push_pulse_width;
			dir_mem[wr_ptr] <= push_dir;
		end
	end

	// pointers, occupancy and credit return
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			credit <= 1'b0;
		end
		else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
			// one credit per pop, a clock later
			credit <= do_pop;
		end
	end

endmodule : move_cmd_queue

// ==== hw/step_counter.sv ====
module step_counter #(
	parameter int WIDTH = 8
) (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic clear,
	input logic count_en,
	input logic [WIDTH-1:0] target,
	output logic reached
);

	logic [WIDTH-1:0] count;
	logic [WIDTH-1:0] count_inc;

	assign count_inc = count + 1'b1;

	// high on the last counting tick, one ahead of the register
	assign reached = (count_inc == target);

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end
		else if (clear && tick) begin
			count <= '0;
		end
		else if (count_en && tick) begin
			count <= count_inc;
		end
	end

	// clear wins over count_en when both are set
	// outside tick cycles the count holds

endmodule : step_counter

// ==== hw/step_tick_gen.sv ====
module step_tick_gen #(
	parameter int TICK_DIV = 4
) (
	input logic clk,
	input logic reset,
	output logic tick
);

	// at least one bit even when TICK_DIV is 1
	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [CNT_W-1:0] div_cnt;

	// tick on the last count of each period
	// with TICK_DIV of 1 the counter sits at zero, tick every clock
	assign tick = (div_cnt == CNT_W'(TICK_DIV - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end
		else if (tick) begin
			// wrap
			div_cnt <= '0;
		end
		else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule : step_tick_gen

// ==== hw/stepper_ctrl_fsm.sv ====
module stepper_ctrl_fsm (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic q_empty,
	input logic [stepper_pkg::PULSE_NUM_W-1:0] q_pulse_num,
	input logic [stepper_pkg::PULSE_WIDTH_W-1:0] q_pulse_width,
	input logic q_dir,
	input logic width_reached,
	input logic num_reached,
	output logic q_pop,
	output logic width_clear,
	output logic width_en,
	output logic num_clear,
	output logic num_en,
	output logic [stepper_pkg::PULSE_WIDTH_W-1:0] width_target,
	output logic [stepper_pkg::PULSE_NUM_W-1:0] num_target,
	output logic step,
	output logic dir,
	output logic busy,
	output logic move_done
);

	import stepper_pkg::*;

	stepper_state_e cur_state;
	stepper_state_e nxt_state;

	// latched command
	logic [PULSE_WIDTH_W-1:0] held_width;
	logic [PULSE_NUM_W-1:0] held_num;
	logic held_dir;
	logic q_zero_len;

	// zero width or zero count means no pulse at all
	assign q_zero_len = (q_pulse_width == '0) || (q_pulse_num == '0);

	assign width_target = held_width;
	assign num_target = held_num;
	assign dir = held_dir;

	// the pop and the done strobe last a single clock, on the tick
	assign q_pop = (cur_state == st_load) && tick;
	assign move_done = (cur_state == st_done) && tick;

	always_comb begin
		nxt_state = cur_state;
		width_clear = 1'b0;
		width_en = 1'b0;
		num_clear = 1'b0;
		num_en = 1'b0;
		step = 1'b0;
		busy = 1'b0;
		case (cur_state)
			st_reset: begin
				nxt_state = st_standby;
				width_clear = 1'b1;
				num_clear = 1'b1;
			end
			st_standby: begin
				if (!q_empty) begin
					nxt_state = st_load;
				end
			end
			st_load: begin
				busy = 1'b1;
				width_clear = 1'b1;
				num_clear = 1'b1;
				nxt_state = q_zero_len ? st_done : st_in_pulse;
			end
			st_in_pulse: begin
				busy = 1'b1;
				step = 1'b1;
				width_en = 1'b1;
				if (width_reached) begin
					nxt_state = st_next_pulse;
				end
				// last pulse of the command
				if ((width_reached && num_reached) || (held_width == '0)) begin
					nxt_state = st_done;
				end
			end
			st_next_pulse: begin
				busy = 1'b1;
				width_clear = 1'b1;
				num_en = 1'b1;
				nxt_state = st_in_pulse;
			end
			st_done: begin
				busy = 1'b1;
				width_clear = 1'b1;
				num_clear = 1'b1;
				nxt_state = st_standby;
			end
			default: nxt_state = st_reset;
		endcase
	end

	// state moves only on tick
	always_ff @(posedge clk) begin
		if (reset) begin
			cur_state <= st_reset;
			held_dir <= 1'b0;
		end
		else begin
			if (tick) begin
				cur_state <= nxt_state;
			end
			if (q_pop) begin
				held_dir <= q_dir;
			end
		end
	end

	// command payload, loaded with the pop
	always_ff @(posedge clk) begin
		if (q_pop) begin
			held_width <= q_pulse_width;
			held_num <= q_pulse_num;
		end
	end

endmodule : stepper_ctrl_fsm

// ==== hw/stepper_pkg.sv ====
`include "stepper_defaults.svh"

package stepper_pkg;

	// width of the pulse count field and of the pulse number counter
	parameter int PULSE_NUM_W = `STEPPER_PULSE_NUM_W;

	// width of the pulse width field and of the pulse width counter
	parameter int PULSE_WIDTH_W = `STEPPER_PULSE_WIDTH_W;

	// controller states
	typedef enum logic [2:0] {
		// after reset, waits for the first tick
		st_reset,
		// idle, watching the queue
		st_standby,
		// pops and latches the head command
		st_load,
		// step high, width counter running
		st_in_pulse,
		// step low for one tick, pulse counter advances
		st_next_pulse,
		// one tick of step low before move_done
		st_done
	} stepper_state_e;

endpackage : stepper_pkg

// ==== hw/stepper_top.sv ====
`include "stepper_defaults.svh"

module stepper_top #(
	parameter int QUEUE_DEPTH = `STEPPER_QUEUE_DEPTH,
	parameter int TICK_DIV = `STEPPER_TICK_DIV
) (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input logic [stepper_pkg::PULSE_NUM_W-1:0] cmd_pulse_num,
	input logic [stepper_pkg::PULSE_WIDTH_W-1:0] cmd_pulse_width,
	input logic cmd_dir,
	output logic cmd_credit,
	output logic step,
	output logic dir,
	output logic busy,
	output logic move_done
);

	import stepper_pkg::*;

	logic tick;

	// queue head toward the controller
	logic q_empty;
	logic q_pop;
	logic [PULSE_NUM_W-1:0] q_pulse_num;
	logic [PULSE_WIDTH_W-1:0] q_pulse_width;
	logic q_dir;

	// counter handshakes
	logic width_clear;
	logic width_en;
	logic width_reached;
	logic [PULSE_WIDTH_W-1:0] width_target;
	logic num_clear;
	logic num_en;
	logic num_reached;
	logic [PULSE_NUM_W-1:0] num_target;

	// clock enable for all timing
	step_tick_gen #(
		.TICK_DIV(TICK_DIV)
	) tick_i (
		.clk(clk),
		.reset(reset),
		.tick(tick)
	);

	// host commands wait here, credits go back on each pop
	move_cmd_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) queue_i (
		.clk(clk),
		.reset(reset),
		.push(cmd_valid),
		.push_pulse_num(cmd_pulse_num),
		.push_pulse_width(cmd_pulse_width),
		.push_dir(cmd_dir),
		.pop(q_pop),
		.empty(q_empty),
		.head_pulse_num(q_pulse_num),
		.head_pulse_width(q_pulse_width),
		.head_dir(q_dir),
		.credit(cmd_credit)
	);

	// ticks of step high within one pulse
	step_counter #(
		.WIDTH(PULSE_WIDTH_W)
	) width_cnt_i (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.clear(width_clear),
		.count_en(width_en),
		.target(width_target),
		.reached(width_reached)
	);

	// pulses sent so far for the current command
	step_counter #(
		.WIDTH(PULSE_NUM_W)
	) num_cnt_i (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.clear(num_clear),
		.count_en(num_en),
		.target(num_target),
		.reached(num_reached)
	);

	stepper_ctrl_fsm ctrl_i (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.q_empty(q_empty),
		.q_pulse_num(q_pulse_num),
		.q_pulse_width(q_pulse_width),
		.q_dir(q_dir),
		.width_reached(width_reached),
		.num_reached(num_reached),
		.q_pop(q_pop),
		.width_clear(width_clear),
		.width_en(width_en),
		.num_clear(num_clear),
		.num_en(num_en),
		.width_target(width_target),
		.num_target(num_target),
		.step(step),
		.dir(dir),
		.busy(busy),
		.move_done(move_done)
	);

endmodule : stepper_top

// ==== include/stepper_defaults.svh ====
`ifndef STEPPER_DEFAULTS_SVH
`define STEPPER_DEFAULTS_SVH

// pulse count field width
`define STEPPER_PULSE_NUM_W 16
// pulse width field, in ticks
`define STEPPER_PULSE_WIDTH_W 8
// queue entries, also the host's starting credit
`define STEPPER_QUEUE_DEPTH 4
// system clocks per tick
`define STEPPER_TICK_DIV 4
`endif

// ==== sim.f ====
+incdir+include
hw/stepper_pkg.sv
hw/step_tick_gen.sv
hw/move_cmd_queue.sv
hw/step_counter.sv
hw/stepper_ctrl_fsm.sv
hw/stepper_top.sv
bench/stepper_tb.sv
